// File: include/mc_settings.svh
`ifndef MC_SETTINGS_SVH
`define MC_SETTINGS_SVH

// host side
`define MC_ADDR_WIDTH         30 // flat host address
`define MC_DATA_WIDTH         32 // write data

// dram address fields
`define MC_BG_WIDTH           2
`define MC_BANK_WIDTH         2
`define MC_ROW_WIDTH          16
`define MC_COL_WIDTH          10
`define MC_NUM_BANKS          16 // bank groups times banks

// outstanding tables, log2 of the slot count
`define MC_READ_ENTRIES_LOG   3 // 8 read slots
`define MC_WRITE_ENTRIES_LOG  2 // 4 write slots

// picks the row bits folded into bank group and bank
`define MC_HASH_SHIFT         4

// cycles a bank stays occupied after select
`define MC_BANK_BUSY_CYCLES   6

`endif

// File: source/mc_pkg.sv
`include "mc_settings.svh"

package mc_pkg;

	typedef enum logic {
		read  = 1'b0,
		write = 1'b1
	} req_kind_e;

	// request as handed in by the host
	typedef struct packed {
		req_kind_e                  kind;
		logic [`MC_ADDR_WIDTH-1:0] addr;
		logic [`MC_DATA_WIDTH-1:0] data;
	} host_req_t;

	// hashed dram coordinates
	typedef struct packed {
		logic [`MC_BG_WIDTH-1:0]   bank_group;
		logic [`MC_BANK_WIDTH-1:0] bank;
		logic [`MC_ROW_WIDTH-1:0]  row;
		logic [`MC_COL_WIDTH-1:0]  column;
	} dram_addr_t;

	// what a selected bank receives, bank itself is in the one-hot select
	typedef struct packed {
		req_kind_e                 kind;
		logic [`MC_ROW_WIDTH-1:0]  row;
		logic [`MC_COL_WIDTH-1:0]  column;
		logic [`MC_DATA_WIDTH-1:0] data;
	} bank_req_t;

endpackage

// File: source/bank_timer.sv
`timescale 1ns/1ps
`include "mc_settings.svh"

module bank_timer import mc_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       select_i,
	input  req_kind_e  kind_i,
	output logic       busy_o,
	output logic       done_rd_o,
	output logic       done_wr_o
);

	localparam int CNT_W = $clog2(`MC_BANK_BUSY_CYCLES + 1);
	localparam logic [CNT_W-1:0] LOAD = CNT_W'(`MC_BANK_BUSY_CYCLES);

	logic [CNT_W-1:0] cnt_q;
	req_kind_e        kind_q;
	logic             last;

	// countdown of remaining busy cycles
	always_ff @(posedge clk) begin
		if (rst_n) begin
			cnt_q <= '0;
		end else if (select_i) begin
			cnt_q <= LOAD;
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (select_i) begin
			kind_q <= kind_i; // which table gets the completion
		end
	end

	assign busy_o = (cnt_q != '0);
	assign last   = (cnt_q == CNT_W'(1)); // final busy cycle

	assign done_rd_o = last & (kind_q == read);
	assign done_wr_o = last & (kind_q == write);

endmodule

// File: source/overflow_guard.sv
`timescale 1ns/1ps
`include "mc_settings.svh"

module overflow_guard import mc_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      issue_valid_i,
	input  req_kind_e                 issue_kind_i,
	input  logic [`MC_NUM_BANKS-1:0]  done_rd_i,
	input  logic [`MC_NUM_BANKS-1:0]  done_wr_i,
	output logic                      stop_read_o,
	output logic                      stop_write_o
);

	localparam int RD_W  = `MC_READ_ENTRIES_LOG + 1; // holds 0 to 8
	localparam int WR_W  = `MC_WRITE_ENTRIES_LOG + 1;
	localparam int CNT_W = $clog2(`MC_NUM_BANKS + 1);
	localparam logic [RD_W-1:0] RD_LIMIT = RD_W'((1 << `MC_READ_ENTRIES_LOG) - 1);
	localparam logic [WR_W-1:0] WR_LIMIT = WR_W'((1 << `MC_WRITE_ENTRIES_LOG) - 1);

	logic [RD_W-1:0]  rd_cnt_q;
	logic [WR_W-1:0]  wr_cnt_q;
	logic [CNT_W-1:0] rd_done;
	logic [CNT_W-1:0] wr_done;
	logic             rd_inc;
	logic             wr_inc;

	function automatic logic [CNT_W-1:0] popcount(input logic [`MC_NUM_BANKS-1:0] vec);
		logic [CNT_W-1:0] sum;
		sum = '0;
		for (int i = 0; i < `MC_NUM_BANKS; i++) begin
			sum = sum + CNT_W'(vec[i]);
		end
		return sum;
	endfunction

	assign rd_done = popcount(done_rd_i);
	assign wr_done = popcount(done_wr_i);
	assign rd_inc  = issue_valid_i & (issue_kind_i == read);
	assign wr_inc  = issue_valid_i & (issue_kind_i == write);

	always_ff @(posedge clk) begin
		if (rst_n) begin
			rd_cnt_q <= '0;
			wr_cnt_q <= '0;
		end else begin
			rd_cnt_q <= rd_cnt_q + RD_W'(rd_inc) - RD_W'(rd_done);
			wr_cnt_q <= wr_cnt_q + WR_W'(wr_inc) - WR_W'(wr_done);
		end
	end

	// one slot kept back for the request sitting in the mapper's output register
	assign stop_read_o  = (rd_cnt_q >= RD_LIMIT);
	assign stop_write_o = (wr_cnt_q >= WR_LIMIT);

endmodule

// File: source/addr_mapper.sv
`timescale 1ns/1ps
`include "mc_settings.svh"

module addr_mapper import mc_pkg::*; (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             in_valid_i,
	input  host_req_t                        host_req_i,
	input  logic                             stop_read_i,
	input  logic                             stop_write_i,
	input  logic [`MC_NUM_BANKS-1:0]         bank_busy_i,
	output logic                             busy_o,
	output logic                             valid_o,
	output bank_req_t                        bank_req_o,
	output logic [`MC_READ_ENTRIES_LOG-1:0]  slot_index_o,
	output logic [`MC_NUM_BANKS-1:0]         bank_valid_o
);

	localparam int HASH_LO = `MC_ADDR_WIDTH - 1 - `MC_HASH_SHIFT; // lowest row bit in the hash
	localparam int BANK_IDX_W = $clog2(`MC_NUM_BANKS);
	localparam int PAD_W = `MC_READ_ENTRIES_LOG - `MC_WRITE_ENTRIES_LOG;
	localparam logic [`MC_NUM_BANKS-1:0] ONE_BANK = 1;

	typedef enum logic [1:0] {
		st_idle,
		st_issue, // outputs carry an issue
		st_wait   // request parked, host held off
	} state_e;

	typedef struct packed {
		req_kind_e                 kind;
		dram_addr_t                addr;
		logic [`MC_DATA_WIDTH-1:0] data;
	} wait_req_t;

	state_e                            state_q;
	state_e                            state_d;
	wait_req_t                         wait_q;
	wait_req_t                         cand;
	dram_addr_t                        in_addr;
	logic [BANK_IDX_W-1:0]             cand_bank;
	logic                              pending;
	logic                              want;
	logic                              kind_stop;
	logic                              blocked;
	logic                              issue;
	logic                              park;
	logic [`MC_READ_ENTRIES_LOG-1:0]   rd_cnt_q;
	logic [`MC_WRITE_ENTRIES_LOG-1:0]  wr_cnt_q;

	// xor bank hashing against high row bits
	always_comb begin
		in_addr.bank_group = host_req_i.addr[5:4] ^ host_req_i.addr[HASH_LO+3 -: 2];
		in_addr.bank       = host_req_i.addr[13:12] ^ host_req_i.addr[HASH_LO+1 -: 2];
		in_addr.row        = host_req_i.addr[`MC_ADDR_WIDTH-1:14];
		in_addr.column     = {host_req_i.addr[11:6], host_req_i.addr[3:0]};
	end

	assign pending = (state_q == st_wait);
	assign want    = pending | in_valid_i; // in_valid_i is ignored while parked

	// parked request has priority, host cannot present while busy
	always_comb begin
		if (pending) begin
			cand = wait_q;
		end else begin
			cand.kind = host_req_i.kind;
			cand.addr = in_addr;
			cand.data = host_req_i.data;
		end
	end

	assign cand_bank = {cand.addr.bank_group, cand.addr.bank};
	assign kind_stop = (cand.kind == read) ? stop_read_i : stop_write_i;

	// bank_valid_o covers the bank selected last cycle, its timer is not busy yet
	assign blocked = bank_busy_i[cand_bank] | bank_valid_o[cand_bank] | kind_stop;
	assign issue   = want & ~blocked;
	assign park    = want & blocked & ~pending; // only a fresh request loads the register

	always_comb begin
		if (issue) begin
			state_d = st_issue;
		end else if (want) begin
			state_d = st_wait;
		end else begin
			state_d = st_idle;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state_q      <= st_idle;
			rd_cnt_q     <= '0;
			wr_cnt_q     <= '0;
			slot_index_o <= '0;
			bank_valid_o <= '0;
		end else begin
			state_q      <= state_d;
			bank_valid_o <= '0;
			if (issue) begin
				bank_valid_o <= ONE_BANK << cand_bank;
				if (cand.kind == read) begin
					slot_index_o <= rd_cnt_q;
					rd_cnt_q     <= rd_cnt_q + 1'b1; // wraps at 8
				end else begin
					slot_index_o <= {{PAD_W{1'b0}}, wr_cnt_q};
					wr_cnt_q     <= wr_cnt_q + 1'b1; // wraps at 4
				end
			end
		end
	end

	// payload, qualified by valid_o and busy_o
	always_ff @(posedge clk) begin
		if (park) begin
			wait_q <= cand; // keeps its own data
		end
		if (issue) begin
			bank_req_o.kind   <= cand.kind;
			bank_req_o.row    <= cand.addr.row;
			bank_req_o.column <= cand.addr.column;
			bank_req_o.data   <= cand.data;
		end
	end

	assign valid_o = (state_q == st_issue);
	assign busy_o  = (state_q == st_wait);

endmodule

// File: source/mc_frontend_top.sv
`timescale 1ns/1ps
`include "mc_settings.svh"

module mc_frontend_top import mc_pkg::*; (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             in_valid_i,
	input  host_req_t                        host_req_i,
	output logic                             busy_o,
	output logic                             valid_o,
	output bank_req_t                        bank_req_o,
	output logic [`MC_READ_ENTRIES_LOG-1:0]  slot_index_o,
	output logic [`MC_NUM_BANKS-1:0]         bank_valid_o
);

	logic                      stop_read;
	logic                      stop_write;
	logic [`MC_NUM_BANKS-1:0]  bank_busy;
	logic [`MC_NUM_BANKS-1:0]  done_rd;
	logic [`MC_NUM_BANKS-1:0]  done_wr;

	addr_mapper u_addr_mapper (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid_i   (in_valid_i),
		.host_req_i   (host_req_i),
		.stop_read_i  (stop_read),
		.stop_write_i (stop_write),
		.bank_busy_i  (bank_busy),
		.busy_o       (busy_o),
		.valid_o      (valid_o),
		.bank_req_o   (bank_req_o),
		.slot_index_o (slot_index_o),
		.bank_valid_o (bank_valid_o)
	);

	overflow_guard u_overflow_guard (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_valid_i (valid_o),
		.issue_kind_i  (bank_req_o.kind),
		.done_rd_i     (done_rd),
		.done_wr_i     (done_wr),
		.stop_read_o   (stop_read),
		.stop_write_o  (stop_write)
	);

	// one occupancy timer per bank
	for (genvar i = 0; i < `MC_NUM_BANKS; i++) begin : g_bank
		bank_timer u_bank_timer (
			.clk       (clk),
			.rst_n     (rst_n),
			.select_i  (bank_valid_o[i]),
			.kind_i    (bank_req_o.kind),
			.busy_o    (bank_busy[i]),
			.done_rd_o (done_rd[i]),
			.done_wr_o (done_wr[i])
		);
	end

endmodule

// File: tb/mc_chk.sv
`timescale 1ns/1ps
`include "mc_settings.svh"

module mc_chk (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      busy_i,
	input  logic                      valid_i,
	input  logic [`MC_NUM_BANKS-1:0]  bank_valid_i
);

	int fail_count = 0; // read by the testbench at the end

	a_select_onehot: assert property (@(posedge clk) disable iff (rst_n)
		$onehot0(bank_valid_i))
		else begin
			fail_count++;
			$error("more than one bank selected at once: %b", bank_valid_i);
		end

	a_valid_has_bank: assert property (@(posedge clk) disable iff (rst_n)
		valid_i == (bank_valid_i != '0))
		else begin
			fail_count++;
			$error("valid_o and bank_valid_o disagree: %b %b", valid_i, bank_valid_i);
		end

	// a stall only ends with the parked request issuing
	a_stall_ends_in_issue: assert property (@(posedge clk) disable iff (rst_n)
		busy_i |=> (busy_i || valid_i))
		else begin
			fail_count++;
			$error("busy_o fell without the parked request issuing");
		end

endmodule

bind addr_mapper mc_chk u_chk (
	.clk          (clk),
	.rst_n        (rst_n),
	.busy_i       (busy_o),
	.valid_i      (valid_o),
	.bank_valid_i (bank_valid_o)
);

// File: tb/mc_monitor.sv
`timescale 1ns/1ps
`include "mc_settings.svh"

module mc_monitor import mc_pkg::*; (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             in_valid_i,
	input  host_req_t                        host_req_i,
	input  logic                             busy_i,
	input  logic                             valid_i,
	input  bank_req_t                        bank_req_i,
	input  logic [`MC_READ_ENTRIES_LOG-1:0]  slot_index_i,
	input  logic [`MC_NUM_BANKS-1:0]         bank_valid_i,
	output int                               errors_o,
	output int                               pending_o,
	output int                               accepted_o,
	output int                               issued_o
);

	localparam int SLOT_W   = `MC_READ_ENTRIES_LOG;
	localparam int RD_SLOTS = 1 << `MC_READ_ENTRIES_LOG;
	localparam int WR_SLOTS = 1 << `MC_WRITE_ENTRIES_LOG;
	localparam int BANK_GAP = `MC_BANK_BUSY_CYCLES + 2; // busy window, then the decision cycle

	host_req_t expect_q[$];  // accepted, not yet issued
	int        rd_done_q[$]; // completion cycle of each outstanding read
	int        wr_done_q[$];
	int        last_issue[`MC_NUM_BANKS] = '{default: -1000};
	int        err_cnt = 0;
	int        acc_cnt = 0;
	int        iss_cnt = 0;
	int        cyc = 0;
	int        rd_slot = 0;
	int        wr_slot = 0;
	logic      rst_seen = 1'b0;

	assign errors_o   = err_cnt;
	assign pending_o  = expect_q.size();
	assign accepted_o = acc_cnt;
	assign issued_o   = iss_cnt;

	// reference address mapping with xor bank hashing
	function automatic dram_addr_t map_addr(input logic [`MC_ADDR_WIDTH-1:0] a);
		dram_addr_t m;
		m.bank_group = a[5:4] ^ a[28:27];
		m.bank       = a[13:12] ^ a[26:25];
		m.row        = a[29:14];
		m.column     = {a[11:6], a[3:0]};
		return m;
	endfunction

	task automatic log_mismatch(input string msg);
		err_cnt++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	task automatic check_issue();
		host_req_t                req;
		dram_addr_t               m;
		logic [3:0]               bank_idx;
		logic [`MC_NUM_BANKS-1:0] onehot;
		logic [SLOT_W-1:0]        slot;
		iss_cnt++;
		if (expect_q.size() == 0) begin
			err_cnt++;
			$display("an issue appeared at %0t with no accepted request left for it", $time);
			return;
		end
		req = expect_q.pop_front(); // acceptance order
		m = map_addr(req.addr);
		bank_idx = {m.bank_group, m.bank};
		onehot = '0;
		onehot[bank_idx] = 1'b1;
		if (bank_req_i.kind != req.kind)
			log_mismatch($sformatf("kind %0d, expected %0d", bank_req_i.kind, req.kind));
		if (bank_req_i.row != m.row)
			log_mismatch($sformatf("row %h, expected %h", bank_req_i.row, m.row));
		if (bank_req_i.column != m.column)
			log_mismatch($sformatf("column %h, expected %h", bank_req_i.column, m.column));
		if (bank_valid_i != onehot)
			log_mismatch($sformatf("bank select %h, expected %h", bank_valid_i, onehot));
		if (req.kind == write && bank_req_i.data != req.data)
			log_mismatch($sformatf("write data %h, expected %h", bank_req_i.data, req.data));
		if (cyc < last_issue[bank_idx] + BANK_GAP)
			log_mismatch($sformatf("bank %0d reissued after %0d cycles, expected at least %0d",
				bank_idx, cyc - last_issue[bank_idx], BANK_GAP));
		last_issue[bank_idx] = cyc;
		if (req.kind == read) begin
			slot = SLOT_W'(rd_slot);
			rd_slot = (rd_slot + 1) % RD_SLOTS;
			while (rd_done_q.size() > 0 && rd_done_q[0] < cyc)
				void'(rd_done_q.pop_front());
			rd_done_q.push_back(cyc + `MC_BANK_BUSY_CYCLES);
			if (rd_done_q.size() > RD_SLOTS - 1)
				log_mismatch($sformatf("%0d reads outstanding", rd_done_q.size()));
		end else begin
			slot = SLOT_W'(wr_slot);
			wr_slot = (wr_slot + 1) % WR_SLOTS;
			while (wr_done_q.size() > 0 && wr_done_q[0] < cyc)
				void'(wr_done_q.pop_front());
			wr_done_q.push_back(cyc + `MC_BANK_BUSY_CYCLES);
			if (wr_done_q.size() > WR_SLOTS - 1)
				log_mismatch($sformatf("%0d writes outstanding", wr_done_q.size()));
		end
		if (slot_index_i != slot)
			log_mismatch($sformatf("slot index %0d, expected %0d", slot_index_i, slot));
	endtask

	// values seen here are the ones of the cycle that just ended
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (rst_seen && (busy_i || valid_i || bank_valid_i != '0))
			log_mismatch($sformatf("busy %b valid %b select %h around reset, expected low",
				busy_i, valid_i, bank_valid_i));
		rst_seen = rst_n;
		if (!rst_n) begin
			if (in_valid_i && !busy_i) begin
				expect_q.push_back(host_req_i);
				acc_cnt++;
			end
			if (valid_i)
				check_issue();
		end
	end

endmodule

// File: tb/mc_tb.sv
`timescale 1ns/1ps
`include "mc_settings.svh"

module mc_tb import mc_pkg::*; ();

	localparam int          RANDOM_REQS = 80;
	localparam int          WAIT_LIMIT  = 200; // cycles per wait
	localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

	logic                             clk;
	logic                             rst_n;
	logic                             in_valid;
	host_req_t                        host_req;
	logic                             busy;
	logic                             valid;
	bank_req_t                        bank_req;
	logic [`MC_READ_ENTRIES_LOG-1:0]  slot_index;
	logic [`MC_NUM_BANKS-1:0]         bank_valid;
	logic [31:0]                      lfsr_q;
	logic                             timed_out;
	int                               tb_errors;
	int                               sent;
	int                               mon_errors;
	int                               mon_pending;
	int                               mon_accepted;
	int                               mon_issued;

	mc_frontend_top u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid_i   (in_valid),
		.host_req_i   (host_req),
		.busy_o       (busy),
		.valid_o      (valid),
		.bank_req_o   (bank_req),
		.slot_index_o (slot_index),
		.bank_valid_o (bank_valid)
	);

	mc_monitor u_monitor (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid_i   (in_valid),
		.host_req_i   (host_req),
		.busy_i       (busy),
		.valid_i      (valid),
		.bank_req_i   (bank_req),
		.slot_index_i (slot_index),
		.bank_valid_i (bank_valid),
		.errors_o     (mon_errors),
		.pending_o    (mon_pending),
		.accepted_o   (mon_accepted),
		.issued_o     (mon_issued)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_q[0]};
			lfsr_q = galois_step(lfsr_q);
		end
	endtask

	// row zero, so the hash leaves the bank bits as they are
	function automatic logic [`MC_ADDR_WIDTH-1:0] addr_for_bank(input logic [3:0] bank_num);
		logic [`MC_ADDR_WIDTH-1:0] a;
		a = '0;
		a[5:4]   = bank_num[3:2];
		a[13:12] = bank_num[1:0];
		return a;
	endfunction

	// one cycle of valid, one idle cycle, then wait for busy_o low
	task automatic send_req(input req_kind_e kind, input logic [`MC_ADDR_WIDTH-1:0] addr,
		input logic [31:0] data, output logic was_stalled);
		int waited;
		waited = 0;
		was_stalled = 1'b0;
		if (timed_out)
			return;
		in_valid = 1'b1;
		host_req.kind = kind;
		host_req.addr = addr;
		host_req.data = data;
		@(negedge clk);
		in_valid = 1'b0;
		was_stalled = busy; // busy_o rises one cycle after a blocked request
		@(negedge clk);
		while (busy && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		sent++;
		if (busy) begin
			$display("timeout: busy_o stayed high for %0d cycles after a request", WAIT_LIMIT);
			tb_errors++;
			timed_out = 1'b1;
		end else if (was_stalled) begin
			@(negedge clk); // spare cycle after a stall
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		if (timed_out)
			return;
		while ((mon_pending != 0 || busy) && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (mon_pending != 0 || busy) begin
			$display("timeout: %0d accepted requests were never issued", mon_pending);
			tb_errors++;
			timed_out = 1'b1;
		end else begin
			repeat (`MC_BANK_BUSY_CYCLES + 2) @(negedge clk); // let every bank complete
		end
	endtask

	initial begin
		logic [31:0] bits;
		logic [31:0] data;
		req_kind_e   kind;
		logic        stalled;
		int          total;
		in_valid = 1'b0;
		host_req = '0;
		rst_n = 1'b1;
		lfsr_q = 32'h7278;
		timed_out = 1'b0;
		tb_errors = 0;
		sent = 0;
		repeat (16) @(negedge clk);
		rst_n = 1'b0;
		@(negedge clk);

		// same hashed bank 4, different rows
		send_req(write, 30'h0000_4011, 32'hcafe_0001, stalled);
		send_req(write, 30'h0800_00c5, 32'hcafe_0002, stalled);
		if (!timed_out && !stalled) begin
			$display("a write to a busy bank was not held off by busy_o");
			tb_errors++;
		end
		drain();

		// reads over eight free banks
		for (int k = 0; k < 8; k++)
			send_req(read, addr_for_bank(4'(k)), 32'h0000_a000 + 32'(k), stalled);
		drain();

		// fourth write hits the write limit
		for (int k = 0; k < 4; k++)
			send_req(write, addr_for_bank(4'(k + 8)), 32'h0000_5a00 + 32'(k), stalled);
		if (!timed_out && !stalled) begin
			$display("the fourth outstanding write was not held off by busy_o");
			tb_errors++;
		end
		drain();

		for (int n = 0; n < RANDOM_REQS; n++) begin
			take_bits(1, bits);
			kind = req_kind_e'(bits[0]);
			take_bits(`MC_ADDR_WIDTH, bits);
			take_bits(`MC_DATA_WIDTH, data);
			send_req(kind, bits[`MC_ADDR_WIDTH-1:0], data, stalled);
		end
		drain();

		if (!timed_out && (mon_accepted != sent || mon_issued != sent)) begin
			$display("%0d requests sent, %0d accepted and %0d issued",
				sent, mon_accepted, mon_issued);
			tb_errors++;
		end
		total = tb_errors + mon_errors + u_dut.u_addr_mapper.u_chk.fail_count;
		$display("errors: %0d monitor, %0d testbench, %0d assertion", mon_errors, tb_errors,
			u_dut.u_addr_mapper.u_chk.fail_count);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+include
source/mc_pkg.sv
source/bank_timer.sv
source/overflow_guard.sv
source/addr_mapper.sv
source/mc_frontend_top.sv
tb/mc_chk.sv
tb/mc_monitor.sv
tb/mc_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mc_tb -f filelist.f -o mc_sim

out=$(./obj_dir/mc_sim +verilator+error+limit+1000)
printf '%s\n' "$out"

# pass only when the testbench reported it
printf '%s\n' "$out" | grep -qx 'Result: PASSED'
